// File: cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ROB_DEPTH  = 8;
    localparam int TAG_W      = 3;     // log2 of ROB_DEPTH
    localparam int DIV_STEPS  = 32;    // one quotient bit per step

    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;

    localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;  // sub, sra
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // base integer funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // m extension funct3
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_DIV    = 3'b100;
    localparam logic [2:0] F3_REM    = 3'b110;
    localparam logic [2:0] F3_REMU   = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } inst_u;

    typedef struct packed {
        logic             start;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        logic [2:0]       funct3;
        alu_op_e          alu_op;   // only read by the alu
    } exec_req_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
    } wb_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
    } commit_t;

endpackage

// File: alu.sv
`timescale 1ns/100ps

module alu
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  exec_req_t req,
    output wb_t       wb
);

    logic [XLEN-1:0] result;
    logic [4:0]      shamt;

    assign shamt = req.b[4:0];

    always_comb begin
        case (req.alu_op)
            ALU_ADD:  result = req.a + req.b;
            ALU_SUB:  result = req.a - req.b;
            ALU_SLL:  result = req.a << shamt;
            ALU_SLT:  result = XLEN'($signed(req.a) < $signed(req.b));
            ALU_SLTU: result = XLEN'(req.a < req.b);
            ALU_XOR:  result = req.a ^ req.b;
            ALU_SRL:  result = req.a >> shamt;
            ALU_SRA:  result = $signed(req.a) >>> shamt;
            ALU_OR:   result = req.a | req.b;
            default:  result = req.a & req.b;
        endcase
    end

    // one cycle issue to writeback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb.valid <= req.start;
            wb.tag   <= req.tag;
            wb.value <= result;
        end
    end

endmodule

// File: multiplier.sv
`timescale 1ns/100ps

module multiplier
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  exec_req_t req,
    output wb_t       wb
);

    logic                     s1_valid;
    logic                     s2_valid;
    logic [TAG_W-1:0]         s1_tag;
    logic [TAG_W-1:0]         s2_tag;
    logic                     s1_hi;
    logic                     s2_hi;
    logic signed [XLEN:0]     s1_a;       // extended by one bit, sign or zero
    logic signed [XLEN:0]     s1_b;
    logic signed [2*XLEN+1:0] s2_prod;
    logic                     a_signed;
    logic                     b_signed;

    assign a_signed = (req.funct3 == F3_MULH) || (req.funct3 == F3_MULHSU);
    assign b_signed = (req.funct3 == F3_MULH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            wb       <= '0;
        end else begin
            s1_valid <= req.start;
            s2_valid <= s1_valid;
            wb.valid <= s2_valid;
            wb.tag   <= s2_tag;
            wb.value <= s2_hi ? s2_prod[2*XLEN-1:XLEN] : s2_prod[XLEN-1:0];
        end
    end

    always_ff @(posedge clk) begin
        s1_tag  <= req.tag;
        s1_hi   <= req.funct3 != F3_MUL;
        s1_a    <= {a_signed & req.a[XLEN-1], req.a};
        s1_b    <= {b_signed & req.b[XLEN-1], req.b};
        s2_tag  <= s1_tag;
        s2_hi   <= s1_hi;
        s2_prod <= s1_a * s1_b;   // 33x33 signed covers all four forms
    end

endmodule

// File: div_control.sv
`timescale 1ns/100ps

module div_control
    import cpu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  exec_req_t        req,
    output logic             div_busy,
    output logic             load,
    output logic             step,
    output logic             finish,
    output logic             wb_valid,
    output logic [TAG_W-1:0] wb_tag
);

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_FIX, S_DONE} div_state_e;

    div_state_e                     state_q;
    logic [$clog2(DIV_STEPS)-1:0]   step_cnt_q;
    logic [TAG_W-1:0]               tag_q;

    assign load     = req.start;
    assign step     = state_q == S_RUN;
    assign finish   = state_q == S_FIX;    // sign and special-case fixup
    assign wb_valid = state_q == S_DONE;
    assign wb_tag   = tag_q;
    assign div_busy = state_q != S_IDLE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= S_IDLE;
            step_cnt_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: if (load) begin
                    state_q    <= S_RUN;
                    step_cnt_q <= '0;
                end
                S_RUN: begin
                    step_cnt_q <= step_cnt_q + 1'b1;
                    if (int'(step_cnt_q) == DIV_STEPS - 1) state_q <= S_FIX;
                end
                S_FIX:   state_q <= S_DONE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) tag_q <= req.tag;
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        req.start |-> state_q == S_IDLE);

endmodule

// File: div_datapath.sv
`timescale 1ns/100ps

module div_datapath
    import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load,
    input  logic            step,
    input  logic            finish,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic [2:0]      funct3,
    output logic [XLEN-1:0] result
);

    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] quo_q;      // holds the dividend, shifts out as quotient shifts in
    logic [XLEN-1:0] dvs_q;
    logic            a_neg_q;
    logic            q_neg_q;
    logic            b_zero_q;
    logic            rem_sel_q;
    logic            signed_op;
    logic [XLEN:0]   trial;
    logic [XLEN-1:0] a_mag;
    logic [XLEN-1:0] b_mag;
    logic [XLEN-1:0] q_fix;
    logic [XLEN-1:0] r_fix;

    assign signed_op = (funct3 == F3_DIV) || (funct3 == F3_REM);
    assign a_mag     = (signed_op && a[XLEN-1]) ? -a : a;
    assign b_mag     = (signed_op && b[XLEN-1]) ? -b : b;
    assign trial     = {rem_q, quo_q[XLEN-1]} - {1'b0, dvs_q};
    assign q_fix     = q_neg_q ? -quo_q : quo_q;
    assign r_fix     = a_neg_q ? -rem_q : rem_q;   // remainder takes the dividend's sign

    // restoring step, keep the trial only when it did not borrow
    always_ff @(posedge clk) begin
        if (load) begin
            rem_q <= '0;
            quo_q <= a_mag;
            dvs_q <= b_mag;
        end else if (step) begin
            if (!trial[XLEN]) begin
                rem_q <= trial[XLEN-1:0];
            end else begin
                rem_q <= {rem_q[XLEN-2:0], quo_q[XLEN-1]};
            end
            quo_q <= {quo_q[XLEN-2:0], ~trial[XLEN]};
        end
    end

    // most negative / -1 needs no case of its own, magnitude 2^31 negates to itself
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_neg_q   <= 1'b0;
            q_neg_q   <= 1'b0;
            b_zero_q  <= 1'b0;
            rem_sel_q <= 1'b0;
            result    <= '0;
        end else begin
            if (load) begin
                a_neg_q   <= signed_op & a[XLEN-1];
                q_neg_q   <= signed_op & (a[XLEN-1] ^ b[XLEN-1]);
                b_zero_q  <= b == '0;
                rem_sel_q <= (funct3 == F3_REM) || (funct3 == F3_REMU);
            end
            if (finish) begin
                if (rem_sel_q) result <= r_fix;        // zero divisor leaves the dividend
                else if (b_zero_q) result <= '1;
                else result <= q_fix;
            end
        end
    end

endmodule

// File: rob.sv
`timescale 1ns/100ps

module rob
    import cpu_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     alloc,
    input  logic [REG_ADDR_W-1:0]    alloc_rd,
    output logic [TAG_W-1:0]         tail_tag,
    output logic                     full,
    output logic [2**REG_ADDR_W-1:0] pending,
    input  wb_t                      alu_wb,
    input  wb_t                      mul_wb,
    input  wb_t                      div_wb,
    output commit_t                  commit
);

    logic [ROB_DEPTH-1:0]  busy_q;     // slot holds an uncommitted entry
    logic [ROB_DEPTH-1:0]  done_q;
    logic [REG_ADDR_W-1:0] rd_q [ROB_DEPTH];
    logic [XLEN-1:0]       value_q [ROB_DEPTH];
    logic [TAG_W-1:0]      head_q;
    logic [TAG_W-1:0]      tail_q;
    logic                  younger_match;
    wb_t                   wb_in [3];

    assign wb_in    = '{alu_wb, mul_wb, div_wb};
    assign tail_tag = tail_q;
    assign full     = busy_q[tail_q];    // tail caught up with head

    assign commit.valid = busy_q[head_q] & done_q[head_q];
    assign commit.rd    = rd_q[head_q];
    assign commit.value = value_q[head_q];

    // every other live entry is younger than the head
    always_comb begin
        younger_match = 1'b0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (busy_q[i] && TAG_W'(i) != head_q && rd_q[i] == rd_q[head_q]) begin
                younger_match = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            pending <= '0;
        end else begin
            for (int k = 0; k < 3; k++) begin
                if (wb_in[k].valid) done_q[wb_in[k].tag] <= 1'b1;
            end
            if (commit.valid) begin
                busy_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
                if (!younger_match) pending[commit.rd] <= 1'b0;
            end
            if (alloc) begin
                busy_q[tail_q] <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
                if (alloc_rd != '0) pending[alloc_rd] <= 1'b1;  // set wins over a same-rd clear
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) rd_q[tail_q] <= alloc_rd;
        for (int k = 0; k < 3; k++) begin
            if (wb_in[k].valid) value_q[wb_in[k].tag] <= wb_in[k].value;
        end
    end

    property p_wb_live(wb_t w);
        @(posedge clk) disable iff (!rst_n) w.valid |-> busy_q[w.tag] && !done_q[w.tag];
    endproperty

    a_alu_wb_live: assert property (p_wb_live(alu_wb));
    a_mul_wb_live: assert property (p_wb_live(mul_wb));
    a_div_wb_live: assert property (p_wb_live(div_wb));

endmodule

// File: arch_regfile.sv
`timescale 1ns/100ps

module arch_regfile
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data,
    input  commit_t               commit
);

    logic [XLEN-1:0] regs_q [2**REG_ADDR_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs_q[i] <= '0;
            end
        end else if (commit.valid && commit.rd != '0) begin
            regs_q[commit.rd] <= commit.value;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs_q[rs1_addr];   // x0 hardwired
    assign rs2_data = (rs2_addr == '0) ? '0 : regs_q[rs2_addr];

endmodule

// File: dispatch.sv
`timescale 1ns/100ps

module dispatch
    import cpu_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     issue,
    input  inst_u                    issue_inst,
    output logic                     busy,
    input  logic                     rob_full,
    input  logic [2**REG_ADDR_W-1:0] pending,
    input  logic                     div_busy,
    input  logic [TAG_W-1:0]         tail_tag,
    output logic [REG_ADDR_W-1:0]    rs1_addr,
    output logic [REG_ADDR_W-1:0]    rs2_addr,
    input  logic [XLEN-1:0]          rs1_data,
    input  logic [XLEN-1:0]          rs2_data,
    output logic                     alloc,
    output logic [REG_ADDR_W-1:0]    alloc_rd,
    output exec_req_t                alu_req,
    output exec_req_t                mul_req,
    output exec_req_t                div_req
);

    logic [6:0]      funct7;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_ext;
    logic            is_reg;
    logic            is_muldiv;
    logic            is_div;
    alu_op_e         alu_op;
    exec_req_t       req;

    assign funct7    = issue_inst.r_view.funct7;   // for I-type this is imm12[11:5]
    assign funct3    = issue_inst.r_view.funct3;
    assign imm_ext   = {{(XLEN-12){issue_inst.i_view.imm12[11]}}, issue_inst.i_view.imm12};
    assign is_reg    = issue_inst.r_view.opcode == OP_REG;
    assign is_muldiv = is_reg && funct7 == FUNCT7_MULDIV;
    assign is_div    = is_muldiv && funct3[2];

    assign rs1_addr = issue_inst.r_view.rs1;
    assign rs2_addr = issue_inst.r_view.rs2;
    assign busy     = rob_full || pending[rs1_addr] || (is_reg && pending[rs2_addr]) ||
                      (is_div && div_busy);
    assign alloc    = issue && !busy;
    assign alloc_rd = issue_inst.r_view.rd;

    always_comb begin
        case (funct3)
            F3_ADD:  alu_op = (is_reg && funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
            F3_SLL:  alu_op = ALU_SLL;
            F3_SLT:  alu_op = ALU_SLT;
            F3_SLTU: alu_op = ALU_SLTU;
            F3_XOR:  alu_op = ALU_XOR;
            F3_SR:   alu_op = (funct7 == FUNCT7_BASE) ? ALU_SRL : ALU_SRA;  // srai too
            F3_OR:   alu_op = ALU_OR;
            F3_AND:  alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        req.start  = 1'b0;
        req.tag    = tail_tag;
        req.a      = rs1_data;
        req.b      = (issue_inst.i_view.opcode == OP_IMM) ? imm_ext : rs2_data;
        req.funct3 = funct3;
        req.alu_op = alu_op;
        alu_req    = req;
        mul_req    = req;
        div_req    = req;
        alu_req.start = alloc && !is_muldiv;
        mul_req.start = alloc && is_muldiv && !funct3[2];
        div_req.start = alloc && is_div;
    end

    a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> !busy);

endmodule

// File: exec_cluster_top.sv
`timescale 1ns/100ps

module exec_cluster_top
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    issue,
    input  inst_u   issue_inst,
    output logic    busy,
    output commit_t commit
);

    logic [REG_ADDR_W-1:0]    rs1_addr;
    logic [REG_ADDR_W-1:0]    rs2_addr;
    logic [XLEN-1:0]          rs1_data;
    logic [XLEN-1:0]          rs2_data;
    logic                     alloc;
    logic [REG_ADDR_W-1:0]    alloc_rd;
    logic [TAG_W-1:0]         tail_tag;
    logic                     rob_full;
    logic [2**REG_ADDR_W-1:0] pending;
    logic                     div_busy;
    logic                     div_load;
    logic                     div_step;
    logic                     div_finish;
    logic                     div_wb_valid;
    logic [TAG_W-1:0]         div_wb_tag;
    logic [XLEN-1:0]          div_result;
    exec_req_t                alu_req;
    exec_req_t                mul_req;
    exec_req_t                div_req;
    wb_t                      alu_wb;
    wb_t                      mul_wb;
    wb_t                      div_wb;

    assign div_wb = '{valid: div_wb_valid, tag: div_wb_tag, value: div_result};

    dispatch u_dispatch (
        .clk(clk), .rst_n(rst_n), .issue(issue), .issue_inst(issue_inst), .busy(busy),
        .rob_full(rob_full), .pending(pending), .div_busy(div_busy), .tail_tag(tail_tag),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alloc(alloc), .alloc_rd(alloc_rd),
        .alu_req(alu_req), .mul_req(mul_req), .div_req(div_req)
    );

    arch_regfile u_arch_regfile (
        .clk(clk), .rst_n(rst_n), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .commit(commit)
    );

    alu u_alu (.clk(clk), .rst_n(rst_n), .req(alu_req), .wb(alu_wb));

    multiplier u_multiplier (.clk(clk), .rst_n(rst_n), .req(mul_req), .wb(mul_wb));

    div_control u_div_control (
        .clk(clk), .rst_n(rst_n), .req(div_req), .div_busy(div_busy),
        .load(div_load), .step(div_step), .finish(div_finish),
        .wb_valid(div_wb_valid), .wb_tag(div_wb_tag)
    );

    div_datapath u_div_datapath (
        .clk(clk), .rst_n(rst_n), .load(div_load), .step(div_step), .finish(div_finish),
        .a(div_req.a), .b(div_req.b), .funct3(div_req.funct3), .result(div_result)
    );

    rob u_rob (
        .clk(clk), .rst_n(rst_n), .alloc(alloc), .alloc_rd(alloc_rd),
        .tail_tag(tail_tag), .full(rob_full), .pending(pending),
        .alu_wb(alu_wb), .mul_wb(mul_wb), .div_wb(div_wb), .commit(commit)
    );

endmodule

// File: tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: tb_exec_cluster.sv
`timescale 1ns/100ps

module tb_exec_cluster
    import cpu_pkg::*;
();

    localparam int          RESET_LIMIT = 10;    // cycles to wait for reset release
    localparam int          OFFER_LIMIT = 200;   // cycles an offer may wait on busy
    localparam int          DRAIN_LIMIT = 400;
    localparam logic [31:0] LFSR_SEED   = 32'hbbf3;

    typedef struct packed {
        logic        is_i;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic        rnd;    // imm taken from the lfsr at apply time
        logic        chk;    // want holds a fixed expected value
        logic [31:0] want;
    } row_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] value;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        issue;
    inst_u       issue_inst;
    logic        busy;
    commit_t     commit;

    row_t        rows [$];
    expect_t     exp_q [$];
    logic [31:0] model_regs [32];
    logic [31:0] lfsr_q = LFSR_SEED;

    tb_clock u_tb_clock (.clk(clk), .rst_n(rst_n));

    exec_cluster_top i_exec_cluster_top (
        .clk(clk), .rst_n(rst_n), .issue(issue), .issue_inst(issue_inst),
        .busy(busy), .commit(commit)
    );

    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    // taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic row_t imm_row(input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [11:0] imm);
        row_t r;
        r = '0;
        r.is_i = 1'b1;
        r.f7   = imm[11:5];
        r.f3   = f3;
        r.rd   = rd;
        r.rs1  = rs1;
        r.imm  = imm;
        return r;
    endfunction

    function automatic row_t reg_row(input logic [6:0] f7, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [4:0] rs2);
        row_t r;
        r = '0;
        r.f7  = f7;
        r.f3  = f3;
        r.rd  = rd;
        r.rs1 = rs1;
        r.rs2 = rs2;
        return r;
    endfunction

    function automatic row_t expect_row(input row_t r, input logic [31:0] v);
        r.chk  = 1'b1;
        r.want = v;
        return r;
    endfunction

    function automatic row_t rand_row(input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [4:0] rs1);
        row_t r;
        r = imm_row(f3, rd, rs1, 12'h000);
        r.rnd = 1'b1;
        return r;
    endfunction

    function automatic inst_u encode(input row_t r);
        inst_u u;
        if (r.is_i) u.i_view = '{r.imm, r.rs1, r.f3, r.rd, OP_IMM};
        else u.r_view = '{r.f7, r.rs2, r.rs1, r.f3, r.rd, OP_REG};
        return u;
    endfunction

    // RV32IM result rules
    function automatic logic [31:0] model_result(input logic is_i, input logic [6:0] f7,
                                                 input logic [2:0] f3,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [63:0]        p_ss;
        logic [63:0]        p_su;
        logic [63:0]        p_uu;
        sa   = a;
        sb   = b;
        p_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        p_su = {{32{a[31]}}, a} * {32'h0, b};
        p_uu = {32'h0, a} * {32'h0, b};
        if (!is_i && f7 == FUNCT7_MULDIV) begin
            case (f3)
                F3_MUL:    return p_uu[31:0];
                F3_MULH:   return p_ss[63:32];
                F3_MULHSU: return p_su[63:32];
                3'b011:    return p_uu[63:32];     // mulhu
                F3_DIV: begin
                    if (b == 0) return '1;
                    if (a == 32'h8000_0000 && b == '1) return a;
                    return sa / sb;
                end
                3'b101:    return (b == 0) ? '1 : a / b;   // divu
                F3_REM: begin
                    if (b == 0) return a;
                    if (a == 32'h8000_0000 && b == '1) return '0;
                    return sa % sb;
                end
                default:   return (b == 0) ? a : a % b;
            endcase
        end
        case (f3)
            F3_ADD:  return (!is_i && f7 == FUNCT7_ALT) ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return {31'h0, sa < sb};
            F3_SLTU: return {31'h0, a < b};
            F3_XOR:  return a ^ b;
            F3_SR:   return f7[5] ? 32'(sa >>> b[4:0]) : a >> b[4:0];
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_table();
        // constant loads and writes to x0
        rows.push_back(expect_row(imm_row(F3_ADD, 1, 0, 12'd100), 32'h64));
        rows.push_back(expect_row(imm_row(F3_ADD, 2, 0, 12'hff9), 32'hffff_fff9));
        rows.push_back(expect_row(imm_row(F3_ADD, 3, 0, 12'h7ff), 32'h7ff));
        rows.push_back(expect_row(imm_row(F3_ADD, 4, 0, 12'h800), 32'hffff_f800));
        rows.push_back(expect_row(imm_row(F3_ADD, 0, 1, 12'd5), 32'h69));
        rows.push_back(expect_row(reg_row(FUNCT7_BASE, F3_ADD, 5, 0, 0), 32'h0));
        rows.push_back(expect_row(imm_row(F3_ADD, 7, 0, 12'd1), 32'h1));
        rows.push_back(expect_row(imm_row(F3_SLL, 6, 7, 12'd31), 32'h8000_0000));
        rows.push_back(expect_row(imm_row(F3_ADD, 8, 0, 12'hfff), 32'hffff_ffff));
        rows.push_back(expect_row(reg_row(FUNCT7_BASE, F3_ADD, 9, 1, 2), 32'h5d));
        rows.push_back(expect_row(reg_row(FUNCT7_ALT, F3_ADD, 10, 2, 1), 32'hffff_ff95));
        rows.push_back(reg_row(FUNCT7_BASE, F3_SLL, 11, 1, 7));
        rows.push_back(reg_row(FUNCT7_BASE, F3_SLT, 12, 2, 1));
        rows.push_back(reg_row(FUNCT7_BASE, F3_SLTU, 13, 2, 1));
        rows.push_back(reg_row(FUNCT7_BASE, F3_XOR, 14, 1, 2));
        rows.push_back(reg_row(FUNCT7_BASE, F3_SR, 15, 2, 7));
        rows.push_back(reg_row(FUNCT7_ALT, F3_SR, 16, 2, 7));
        rows.push_back(reg_row(FUNCT7_BASE, F3_OR, 17, 3, 4));
        rows.push_back(reg_row(FUNCT7_BASE, F3_AND, 18, 2, 3));
        rows.push_back(imm_row(F3_SLT, 19, 2, 12'd5));
        rows.push_back(imm_row(F3_SLTU, 20, 1, 12'hfff));
        rows.push_back(imm_row(F3_XOR, 21, 1, 12'hfff));
        rows.push_back(imm_row(F3_OR, 22, 1, 12'h0f0));
        rows.push_back(imm_row(F3_AND, 23, 2, 12'h0ff));
        rows.push_back(imm_row(F3_SLL, 24, 1, 12'h004));
        rows.push_back(imm_row(F3_SR, 25, 2, 12'h004));
        rows.push_back(imm_row(F3_SR, 26, 2, 12'h404));    // srai
        rows.push_back(expect_row(reg_row(FUNCT7_MULDIV, F3_MUL, 27, 1, 2), 32'hffff_fd44));
        rows.push_back(reg_row(FUNCT7_MULDIV, F3_MULH, 28, 2, 8));
        rows.push_back(reg_row(FUNCT7_MULDIV, F3_MULHSU, 29, 2, 8));
        rows.push_back(reg_row(FUNCT7_MULDIV, 3'b011, 30, 2, 8));
        rows.push_back(expect_row(reg_row(FUNCT7_MULDIV, F3_DIV, 9, 1, 2), 32'hffff_fff2));
        rows.push_back(reg_row(FUNCT7_MULDIV, 3'b101, 10, 2, 1));
        rows.push_back(expect_row(reg_row(FUNCT7_MULDIV, F3_REM, 11, 1, 2), 32'h2));
        rows.push_back(reg_row(FUNCT7_MULDIV, F3_REMU, 12, 2, 1));
        // divide by zero and overflow
        rows.push_back(expect_row(reg_row(FUNCT7_MULDIV, F3_DIV, 13, 1, 0), 32'hffff_ffff));
        rows.push_back(expect_row(reg_row(FUNCT7_MULDIV, F3_REM, 14, 1, 0), 32'h64));
        rows.push_back(expect_row(reg_row(FUNCT7_MULDIV, 3'b101, 15, 1, 0), 32'hffff_ffff));
        rows.push_back(expect_row(reg_row(FUNCT7_MULDIV, F3_REMU, 16, 2, 0), 32'hffff_fff9));
        rows.push_back(expect_row(reg_row(FUNCT7_MULDIV, F3_DIV, 17, 6, 8), 32'h8000_0000));
        rows.push_back(expect_row(reg_row(FUNCT7_MULDIV, F3_REM, 18, 6, 8), 32'h0));
        // mixed traffic behind a divide
        rows.push_back(rand_row(F3_ADD, 20, 0));
        rows.push_back(rand_row(F3_ADD, 21, 0));
        rows.push_back(reg_row(FUNCT7_MULDIV, F3_DIV, 19, 20, 21));
        rows.push_back(reg_row(FUNCT7_BASE, F3_ADD, 22, 1, 2));
        rows.push_back(rand_row(F3_XOR, 23, 3));
        rows.push_back(reg_row(FUNCT7_ALT, F3_ADD, 24, 4, 1));
        rows.push_back(imm_row(F3_AND, 26, 3, 12'h055));
        rows.push_back(reg_row(FUNCT7_BASE, F3_OR, 27, 1, 4));
        rows.push_back(reg_row(FUNCT7_BASE, F3_ADD, 25, 19, 20));   // needs the quotient
        rows.push_back(reg_row(FUNCT7_MULDIV, F3_REM, 28, 20, 21));
    endtask

    task automatic apply_row(input row_t r);
        inst_u       inst;
        logic [31:0] a;
        logic [31:0] b;
        expect_t     e;
        int          waited;
        if (r.rnd) begin
            r.imm = rand_bits(12);
            r.f7  = r.imm[11:5];
        end
        inst    = encode(r);
        a       = model_regs[r.rs1];
        b       = r.is_i ? {{20{r.imm[11]}}, r.imm} : model_regs[r.rs2];
        e.rd    = r.rd;
        e.value = r.chk ? r.want : model_result(r.is_i, r.f7, r.f3, a, b);
        @(posedge clk);
        issue      <= 1'b0;
        issue_inst <= inst;
        waited = 0;
        @(negedge clk);
        while (busy) begin
            waited++;
            assert (waited <= OFFER_LIMIT) else begin
                $display("busy never dropped, instruction could not be issued");
                fail_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        issue <= 1'b1;   // held for exactly one cycle
        exp_q.push_back(e);
        if (r.rd != 0) model_regs[r.rd] = e.value;
    endtask

    // commit checker samples mid-cycle
    always @(negedge clk) begin
        expect_t e;
        if (rst_n && commit.valid) begin
            assert (exp_q.size() > 0) else begin
                $display("commit seen with no instruction outstanding");
                fail_run();
            end
            e = exp_q.pop_front();
            assert (commit.rd == e.rd) else begin
                $display("[ERROR] commit.rd got %h expected %h", commit.rd, e.rd);
                fail_run();
            end
            assert (commit.value == e.value) else begin
                $display("[ERROR] commit.value got %h expected %h", commit.value, e.value);
                fail_run();
            end
        end
    end

    initial begin
        int waited;
        issue      = 1'b0;
        issue_inst = '0;
        foreach (model_regs[i]) model_regs[i] = '0;
        build_table();
        waited = 0;
        while (rst_n !== 1'b1) begin
            waited++;
            assert (waited <= RESET_LIMIT) else begin
                $display("reset was never released");
                fail_run();
            end
            @(posedge clk);
        end
        @(negedge clk);
        assert (!busy) else begin
            $display("busy high right after reset");
            fail_run();
        end
        repeat (4) @(posedge clk);   // idle cycles where any commit is flagged
        foreach (rows[i]) apply_row(rows[i]);
        @(posedge clk);
        issue <= 1'b0;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            assert (waited <= DRAIN_LIMIT) else begin
                $display("commits stopped before all instructions retired");
                fail_run();
            end
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: tb.f
cpu_pkg.sv
alu.sv
multiplier.sv
div_control.sv
div_datapath.sv
rob.sv
arch_regfile.sv
dispatch.sv
exec_cluster_top.sv
tb_clock.sv
tb_exec_cluster.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_exec_cluster -f tb.f \
    --Mdir obj_dir -o sim_exec_cluster

./obj_dir/sim_exec_cluster
